// ==== rtl/fcu_pkg.sv ====
package fcu_pkg;

	// ====================
	// Widths
	// ====================

	// Operand and result width of the flow pipe
	localparam int data_w = 64;
	// Width of one issued micro-op word
	localparam int uop_w = 32;
	// APB address and data widths
	localparam int apb_aw = 4;
	localparam int apb_dw = 32;
	// Event counter width
	localparam int cnt_w = 32;
	// Interrupt level width, six bits covers levels 0 to 63
	localparam int irq_w = 6;

	// ====================
	// Opcodes and conditions
	// ====================

	localparam logic [3:0] op_nop    = 4'h0;
	localparam logic [3:0] op_bcc    = 4'h1;
	localparam logic [3:0] op_bsr    = 4'h2;
	localparam logic [3:0] op_jsr    = 4'h3;
	localparam logic [3:0] op_ibcc   = 4'h4;
	localparam logic [3:0] op_dbcc   = 4'h5;
	localparam logic [3:0] op_ret    = 4'h6;
	localparam logic [3:0] op_irqchk = 4'h7;

	// Signed compares use lt and ge, unsigned ones ltu and geu
	localparam logic [3:0] cc_eq     = 4'h0;
	localparam logic [3:0] cc_ne     = 4'h1;
	localparam logic [3:0] cc_lt     = 4'h2;
	localparam logic [3:0] cc_ge     = 4'h3;
	localparam logic [3:0] cc_ltu    = 4'h4;
	localparam logic [3:0] cc_geu    = 4'h5;
	localparam logic [3:0] cc_always = 4'h6;
	localparam logic [3:0] cc_never  = 4'h7;

	// The same word is read as a branch or as a jump
	// Bit 27 is the top cond bit in one view and the link flag in the other
	typedef union packed {
		struct packed {
			logic [3:0]  opcode;
			logic [3:0]  cond;
			logic [23:0] disp;
		} br;
		struct packed {
			logic [3:0]  opcode;
			logic        link;
			logic [26:0] target;
		} jmp;
	} fcu_uop_u;

	// ====================
	// Registers and constants
	// ====================

	localparam logic [apb_aw-1:0] reg_ctrl  = 4'h0;
	localparam logic [apb_aw-1:0] reg_taken = 4'h4;
	localparam logic [apb_aw-1:0] reg_flow  = 4'h8;
	// Position of mie in the control word, ipl sits in the low bits
	localparam int ctrl_mie_bit = 8;

	// Level 63 is non-maskable
	localparam logic [irq_w-1:0] nmi_level = 6'd63;
	// Link value is the address of the next instruction
	localparam logic [data_w-1:0] link_offset = 64'd4;

	// APB slave phase encodings
	localparam int st_w = 2;
	localparam logic [st_w-1:0] st_idle   = 2'd0;
	localparam logic [st_w-1:0] st_setup  = 2'd1;
	localparam logic [st_w-1:0] st_access = 2'd2;

endpackage

// ==== rtl/fcu_event_counter.sv ====
module fcu_event_counter (
	input  logic                      clk,
	input  logic                      rst_n_i,
	input  logic                      inc_i,
	input  logic                      clr_i,
	output logic [fcu_pkg::cnt_w-1:0] count_o
);
	import fcu_pkg::*;

	logic [cnt_w-1:0] count_q;
	logic             at_max;

	// Counter sticks once every bit is set
	assign at_max = &count_q;

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
			count_q <= '0;
		// Software clear beats a same-cycle event
		else if (clr_i)
			count_q <= '0;
		else if (inc_i && !at_max)
			count_q <= count_q + 1'b1;
	end

	assign count_o = count_q;

endmodule

// ==== rtl/fcu_apb_fsm.sv ====
module fcu_apb_fsm (
	input  logic                       clk,
	input  logic                       rst_n_i,
	input  logic                       psel_i,
	input  logic                       penable_i,
	input  logic                       pwrite_i,
	input  logic [fcu_pkg::apb_aw-1:0] paddr_i,
	output logic                       pready_o,
	output logic                       wr_en_o,
	output logic                       rd_en_o,
	output logic [fcu_pkg::apb_aw-1:0] addr_o
);
	import fcu_pkg::*;

	// Phase of the previous cycle and phase of the current one
	logic [st_w-1:0]   state_q;
	logic [st_w-1:0]   state_d;
	logic [apb_aw-1:0] addr_q;

	// The current phase follows from the bus and from what came before it
	always_comb
	begin
		state_d = st_idle;
		case (state_q)
			st_setup:
			begin
				// Access only counts after a setup phase
				if (psel_i && penable_i)
					state_d = st_access;
				else if (psel_i)
					state_d = st_setup;
			end
			default:
			begin
				// A penable with no setup before it falls through to idle
				if (psel_i && !penable_i)
					state_d = st_setup;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
			state_q <= st_idle;
		else
			state_q <= state_d;
	end

	// Address is captured at the end of setup and held through access
	always_ff @(posedge clk)
	begin
		if (state_d == st_setup)
			addr_q <= paddr_i;
	end

	// No wait states, so ready and the strobe share the access cycle
	assign pready_o = (state_d == st_access);
	assign wr_en_o  = pready_o && pwrite_i;
	assign rd_en_o  = pready_o && !pwrite_i;
	assign addr_o   = addr_q;

endmodule

// ==== rtl/fcu_csr.sv ====
module fcu_csr (
	input  logic                       clk,
	input  logic                       rst_n_i,
	input  logic                       wr_en_i,
	input  logic                       rd_en_i,
	input  logic [fcu_pkg::apb_aw-1:0] addr_i,
	input  logic [fcu_pkg::apb_dw-1:0] pwdata_i,
	input  logic [fcu_pkg::irq_w-1:0]  irq_level_i,
	input  logic                       taken_i,
	input  logic                       flow_i,
	output logic [fcu_pkg::apb_dw-1:0] prdata_o,
	output logic                       irq_pending_o
);
	import fcu_pkg::*;

	logic             mie_q;
	logic [irq_w-1:0] ipl_q;
	logic             clr_taken;
	logic             clr_flow;
	logic [cnt_w-1:0] taken_cnt;
	logic [cnt_w-1:0] flow_cnt;
	logic [apb_dw-1:0] ctrl_word;

	// ====================
	// Control register
	// ====================

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			mie_q <= 1'b0;
			ipl_q <= '0;
		end
		else if (wr_en_i && addr_i == reg_ctrl)
		begin
			mie_q <= pwdata_i[ctrl_mie_bit];
			ipl_q <= pwdata_i[irq_w-1:0];
		end
	end

	// NMI ignores both mie and the priority level
	assign irq_pending_o = (irq_level_i == nmi_level) || (mie_q && irq_level_i > ipl_q);

	// ====================
	// Event counters
	// ====================

	// Any write to a counter clears it, the data is ignored
	assign clr_taken = wr_en_i && addr_i == reg_taken;
	assign clr_flow  = wr_en_i && addr_i == reg_flow;

	fcu_event_counter u_taken_cnt (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.inc_i   (taken_i),
		.clr_i   (clr_taken),
		.count_o (taken_cnt)
	);

	fcu_event_counter u_flow_cnt (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.inc_i   (flow_i),
		.clr_i   (clr_flow),
		.count_o (flow_cnt)
	);

	// Read mux, driven only while the read strobe is up
	always_comb
	begin
		ctrl_word = '0;
		ctrl_word[ctrl_mie_bit] = mie_q;
		ctrl_word[irq_w-1:0] = ipl_q;
		prdata_o = '0;
		if (rd_en_i)
		begin
			case (addr_i)
				reg_ctrl:  prdata_o = ctrl_word;
				reg_taken: prdata_o = taken_cnt;
				reg_flow:  prdata_o = flow_cnt;
				default:   prdata_o = '0;
			endcase
		end
	end

endmodule

// ==== rtl/fcu_branch_eval.sv ====
module fcu_branch_eval (
	input  logic                       clk,
	input  logic                       rst_n_i,
	input  logic                       valid_i,
	input  fcu_pkg::fcu_uop_u          uop_i,
	input  logic [fcu_pkg::data_w-1:0] a_i,
	input  logic [fcu_pkg::data_w-1:0] b_i,
	input  logic                       irq_pending_i,
	output logic                       takb_o
);
	import fcu_pkg::*;

	logic [data_w-1:0] a_inc;
	logic [data_w-1:0] a_dec;
	logic              taken_d;
	logic              takb_q;

	// Applies one condition code to a pair of operands
	function automatic logic cond_met(
		input logic [data_w-1:0] x,
		input logic [data_w-1:0] y,
		input logic [3:0]        cc
	);
		logic r;
		case (cc)
			cc_eq:     r = (x == y);
			cc_ne:     r = (x != y);
			cc_lt:     r = ($signed(x) < $signed(y));
			cc_ge:     r = ($signed(x) >= $signed(y));
			cc_ltu:    r = (x < y);
			cc_geu:    r = (x >= y);
			cc_always: r = 1'b1;
			default:   r = 1'b0;
		endcase
		return r;
	endfunction

	// Loop branches compare the updated count, not the old one
	assign a_inc = a_i + data_w'(1);
	assign a_dec = a_i - data_w'(1);

	always_comb
	begin
		case (uop_i.br.opcode)
			op_bcc:    taken_d = cond_met(a_i, b_i, uop_i.br.cond);
			op_ibcc:   taken_d = cond_met(a_inc, b_i, uop_i.br.cond);
			op_dbcc:   taken_d = cond_met(a_dec, b_i, uop_i.br.cond);
			op_bsr, op_jsr, op_ret:
				taken_d = 1'b1;
			op_irqchk: taken_d = irq_pending_i;
			default:   taken_d = 1'b0;
		endcase
	end

	// One cycle behind the issue port, low when nothing was issued
	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
			takb_q <= 1'b0;
		else
			takb_q <= valid_i && taken_d;
	end

	assign takb_o = takb_q;

endmodule

// ==== rtl/fcu_result_unit.sv ====
module fcu_result_unit (
	input  logic                       clk,
	input  logic                       rst_n_i,
	input  logic                       valid_i,
	input  fcu_pkg::fcu_uop_u          uop_i,
	input  logic [fcu_pkg::data_w-1:0] pc_i,
	input  logic [fcu_pkg::data_w-1:0] a_i,
	input  logic [fcu_pkg::data_w-1:0] t_i,
	input  logic [fcu_pkg::data_w-1:0] imm_i,
	output logic                       res_valid_o,
	output logic [fcu_pkg::data_w-1:0] res_o,
	output logic                       we_o,
	output logic                       flow_o
);
	import fcu_pkg::*;

	logic [data_w-1:0] res_d;
	logic [data_w-1:0] res_q;
	logic              we_d;
	logic              we_q;
	logic              valid_q;
	logic              flow_q;

	// ====================
	// Write-back value
	// ====================

	always_comb
	begin
		res_d = '0;
		we_d = 1'b0;
		case (uop_i.jmp.opcode)
			op_bsr, op_jsr:
			begin
				// Subroutine calls only write the link when asked to
				res_d = pc_i + link_offset;
				we_d = uop_i.jmp.link;
			end
			op_ibcc:
			begin
				// Updated loop count goes back to the a register
				res_d = a_i + data_w'(1);
				we_d = 1'b1;
			end
			op_dbcc:
			begin
				res_d = a_i - data_w'(1);
				we_d = 1'b1;
			end
			op_ret:
			begin
				// Stack pointer adjusted by the immediate
				res_d = t_i + imm_i;
				we_d = 1'b1;
			end
			default:
			begin
				res_d = '0;
				we_d = 1'b0;
			end
		endcase
	end

	// Value is forced to zero when nothing was issued
	always_ff @(posedge clk)
	begin
		res_q <= valid_i ? res_d : '0;
	end

	// ====================
	// Control flags
	// ====================

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			valid_q <= 1'b0;
			we_q <= 1'b0;
			flow_q <= 1'b0;
		end
		else
		begin
			valid_q <= valid_i;
			we_q <= valid_i && we_d;
			flow_q <= valid_i && (uop_i.jmp.opcode != op_nop);
		end
	end

	assign res_valid_o = valid_q;
	assign res_o = res_q;
	assign we_o = we_q;
	assign flow_o = flow_q;

endmodule

// ==== rtl/fcu_top.sv ====
module fcu_top (
	input  logic                       clk,
	input  logic                       rst_n_i,
	input  logic                       uop_valid_i,
	input  logic [fcu_pkg::uop_w-1:0]  uop_i,
	input  logic [fcu_pkg::data_w-1:0] pc_i,
	input  logic [fcu_pkg::data_w-1:0] a_i,
	input  logic [fcu_pkg::data_w-1:0] b_i,
	input  logic [fcu_pkg::data_w-1:0] t_i,
	input  logic [fcu_pkg::data_w-1:0] imm_i,
	input  logic [fcu_pkg::irq_w-1:0]  irq_level_i,
	output logic                       res_valid_o,
	output logic                       takb_o,
	output logic [fcu_pkg::data_w-1:0] res_o,
	output logic                       we_o,
	input  logic                       psel_i,
	input  logic                       penable_i,
	input  logic                       pwrite_i,
	input  logic [fcu_pkg::apb_aw-1:0] paddr_i,
	input  logic [fcu_pkg::apb_dw-1:0] pwdata_i,
	output logic [fcu_pkg::apb_dw-1:0] prdata_o,
	output logic                       pready_o
);
	import fcu_pkg::*;

	// Register strobes from the bus side into the register file
	logic              wr_en;
	logic              rd_en;
	logic [apb_aw-1:0] csr_addr;
	// Status back to the pipe and events back to the counters
	logic              irq_pending;
	logic              flow;

	fcu_apb_fsm u_apb_fsm (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.psel_i    (psel_i),
		.penable_i (penable_i),
		.pwrite_i  (pwrite_i),
		.paddr_i   (paddr_i),
		.pready_o  (pready_o),
		.wr_en_o   (wr_en),
		.rd_en_o   (rd_en),
		.addr_o    (csr_addr)
	);

	fcu_csr u_csr (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.wr_en_i       (wr_en),
		.rd_en_i       (rd_en),
		.addr_i        (csr_addr),
		.pwdata_i      (pwdata_i),
		.irq_level_i   (irq_level_i),
		.taken_i       (takb_o),
		.flow_i        (flow),
		.prdata_o      (prdata_o),
		.irq_pending_o (irq_pending)
	);

	// The registered taken flag also feeds the taken counter
	fcu_branch_eval u_branch_eval (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.valid_i       (uop_valid_i),
		.uop_i         (uop_i),
		.a_i           (a_i),
		.b_i           (b_i),
		.irq_pending_i (irq_pending),
		.takb_o        (takb_o)
	);

	fcu_result_unit u_result_unit (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.valid_i     (uop_valid_i),
		.uop_i       (uop_i),
		.pc_i        (pc_i),
		.a_i         (a_i),
		.t_i         (t_i),
		.imm_i       (imm_i),
		.res_valid_o (res_valid_o),
		.res_o       (res_o),
		.we_o        (we_o),
		.flow_o      (flow)
	);

endmodule

// ==== sim/fcu_asserts.sv ====
module fcu_asserts (
	input logic clk,
	input logic rst_n_i,
	input logic psel_i,
	input logic penable_i,
	input logic pready_o,
	input logic res_valid_o,
	input logic takb_o,
	input logic we_o
);
	timeunit 1ns;
	timeprecision 1ps;

	// Ready belongs to an access cycle that directly follows a setup cycle
	assert property (@(posedge clk) disable iff (!rst_n_i)
		pready_o |-> psel_i && penable_i && $past(psel_i && !penable_i))
	else
		$error("pready_o raised outside an APB access phase");

	// First cycle out of reset
	assert property (@(posedge clk)
		(rst_n_i && !$past(rst_n_i)) |-> !res_valid_o && !takb_o && !we_o && !pready_o)
	else
		$error("outputs not low in the cycle after reset");

	assert property (@(posedge clk) disable iff (!rst_n_i) we_o |-> res_valid_o)
	else
		$error("we_o raised without res_valid_o");

endmodule

bind fcu_top fcu_asserts u_asserts (
	.clk         (clk),
	.rst_n_i     (rst_n_i),
	.psel_i      (psel_i),
	.penable_i   (penable_i),
	.pready_o    (pready_o),
	.res_valid_o (res_valid_o),
	.takb_o      (takb_o),
	.we_o        (we_o)
);

// ==== sim/fcu_tb.sv ====
module fcu_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import fcu_pkg::*;

	// ====================
	// Test lengths
	// ====================

	localparam int n_branch = 400;
	localparam int n_link = 100;
	localparam int n_irq_rounds = 8;
	localparam int n_irq = 40;
	// Each APB transfer takes three cycles, and a counter check runs six of them
	localparam int max_cycles = 2 * (n_branch + n_link + n_irq_rounds * (n_irq + 30) + 200);

	logic        clk;
	logic        rst_n_i;
	logic        uop_valid_i;
	logic [31:0] uop_i;
	logic [63:0] pc_i;
	logic [63:0] a_i;
	logic [63:0] b_i;
	logic [63:0] t_i;
	logic [63:0] imm_i;
	logic [5:0]  irq_level_i;
	logic        res_valid_o;
	logic        takb_o;
	logic [63:0] res_o;
	logic        we_o;
	logic        psel_i;
	logic        penable_i;
	logic        pwrite_i;
	logic [3:0]  paddr_i;
	logic [31:0] pwdata_i;
	logic [31:0] prdata_o;
	logic        pready_o;

	// Reference state, the expected outputs belong to the micro-op of the previous cycle
	logic [31:0] lfsr = 32'hc3c5_fa8a;
	logic        exp_valid = 1'b0;
	logic        exp_takb = 1'b0;
	logic        exp_we = 1'b0;
	logic [63:0] exp_res = '0;
	logic        mie_m = 1'b0;
	logic [5:0]  ipl_m = '0;
	logic [31:0] taken_m = '0;
	logic [31:0] flow_m = '0;
	int          cycles = 0;

	fcu_top uut (.*);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Hard stop in case the DUT or a task never gets past a wait
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles)
		begin
			$display("Timeout after %0d cycles, the test sequence did not complete", cycles);
			$display("Result: FAILED");
			$fatal(1, "simulation timed out");
		end
	end

	// ====================
	// Random numbers
	// ====================

	// Taps 32, 22, 2 and 1, one step per bit handed out
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r = {r[62:0], fb};
		end
		return r;
	endfunction

	// Most picks land on equal values, neighbours or the sign boundary
	function automatic logic [63:0] pick_operand(input logic [63:0] other);
		logic [2:0]  sel;
		logic [63:0] v;
		sel = 3'(rand_bits(3));
		case (sel)
			3'd2: v = other;
			3'd3: v = other + 64'd1;
			3'd4: v = other - 64'd1;
			3'd5: v = 64'h8000_0000_0000_0000;
			3'd6: v = 64'h7fff_ffff_ffff_ffff;
			3'd7: v = rand_bits(1) == 64'd1 ? '1 : '0;
			default: v = rand_bits(64);
		endcase
		return v;
	endfunction

	// ====================
	// Reference model
	// ====================

	// Signed order is the unsigned order with both sign bits flipped
	function automatic logic cond_holds(
		input logic [63:0] x,
		input logic [63:0] y,
		input logic [3:0]  cc
	);
		logic [63:0] xs;
		logic [63:0] ys;
		logic        eq;
		logic        below;
		logic        below_s;
		logic        r;
		xs = x ^ {1'b1, 63'b0};
		ys = y ^ {1'b1, 63'b0};
		eq = (x == y);
		below = (x < y);
		below_s = (xs < ys);
		case (cc)
			cc_eq:     r = eq;
			cc_ne:     r = !eq;
			cc_lt:     r = below_s;
			cc_ge:     r = !below_s;
			cc_ltu:    r = below;
			cc_geu:    r = !below;
			cc_always: r = 1'b1;
			default:   r = 1'b0;
		endcase
		return r;
	endfunction

	task automatic check_value(input string name, input logic [63:0] act, input logic [63:0] exp);
		if (act !== exp)
		begin
			$display("FAIL t=%0t %s: got %h, expected %h", $time, name, act, exp);
			$display("Result: FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic compare_outputs();
		check_value("res_valid_o", 64'(res_valid_o), 64'(exp_valid));
		check_value("takb_o", 64'(takb_o), 64'(exp_takb));
		check_value("res_o", res_o, exp_res);
		check_value("we_o", 64'(we_o), 64'(exp_we));
	endtask

	// Checks the previous result, then drives one micro-op and predicts its outcome
	task automatic issue_uop(
		input logic        valid,
		input logic [31:0] uop,
		input logic [63:0] pc,
		input logic [63:0] a,
		input logic [63:0] b,
		input logic [63:0] t,
		input logic [63:0] imm,
		input logic [5:0]  lvl
	);
		logic [3:0] op;
		logic       pend;
		@(negedge clk);
		compare_outputs();
		uop_valid_i = valid;
		uop_i = uop;
		pc_i = pc;
		a_i = a;
		b_i = b;
		t_i = t;
		imm_i = imm;
		irq_level_i = lvl;
		op = uop[31:28];
		// Pending uses the control values that are live while the micro-op is sampled
		pend = (lvl == nmi_level) || (mie_m && lvl > ipl_m);
		exp_takb = 1'b0;
		exp_res = '0;
		exp_we = 1'b0;
		if (valid)
		begin
			case (op)
				op_bcc:
					exp_takb = cond_holds(a, b, uop[27:24]);
				op_ibcc:
				begin
					exp_takb = cond_holds(a + 64'd1, b, uop[27:24]);
					exp_res = a + 64'd1;
					exp_we = 1'b1;
				end
				op_dbcc:
				begin
					exp_takb = cond_holds(a - 64'd1, b, uop[27:24]);
					exp_res = a - 64'd1;
					exp_we = 1'b1;
				end
				op_bsr, op_jsr:
				begin
					exp_takb = 1'b1;
					exp_res = pc + link_offset;
					// Bit 27 is the link flag in the jump format
					exp_we = uop[27];
				end
				op_ret:
				begin
					exp_takb = 1'b1;
					exp_res = t + imm;
					exp_we = 1'b1;
				end
				op_irqchk:
					exp_takb = pend;
				default:
					exp_takb = 1'b0;
			endcase
			if (exp_takb)
				taken_m = taken_m + 32'd1;
			if (op != op_nop)
				flow_m = flow_m + 32'd1;
		end
		exp_valid = valid;
	endtask

	task automatic flush_pipe();
		issue_uop(1'b0, '0, '0, '0, '0, '0, '0, '0);
	endtask

	// ====================
	// APB transfers
	// ====================

	task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
		@(negedge clk);
		psel_i = 1'b1;
		penable_i = 1'b0;
		pwrite_i = 1'b1;
		paddr_i = addr;
		pwdata_i = data;
		@(negedge clk);
		penable_i = 1'b1;
		#1;
		check_value("pready_o", 64'(pready_o), 64'd1);
		@(negedge clk);
		psel_i = 1'b0;
		penable_i = 1'b0;
		pwrite_i = 1'b0;
	endtask

	// Read data is only there during the access cycle
	task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
		@(negedge clk);
		psel_i = 1'b1;
		penable_i = 1'b0;
		pwrite_i = 1'b0;
		paddr_i = addr;
		@(negedge clk);
		penable_i = 1'b1;
		#1;
		check_value("pready_o", 64'(pready_o), 64'd1);
		data = prdata_o;
		@(negedge clk);
		psel_i = 1'b0;
		penable_i = 1'b0;
	endtask

	// Compares both counters with the model, then clears them and reads zero back
	task automatic check_counters();
		logic [31:0] rdata;
		apb_read(reg_taken, rdata);
		check_value("taken count", 64'(rdata), 64'(taken_m));
		apb_read(reg_flow, rdata);
		check_value("flow count", 64'(rdata), 64'(flow_m));
		apb_write(reg_taken, 32'(rand_bits(32)));
		apb_write(reg_flow, 32'(rand_bits(32)));
		taken_m = '0;
		flow_m = '0;
		apb_read(reg_taken, rdata);
		check_value("taken count", 64'(rdata), 64'd0);
		apb_read(reg_flow, rdata);
		check_value("flow count", 64'(rdata), 64'd0);
	endtask

	// ====================
	// Test sequence
	// ====================

	initial
	begin
		logic [31:0] rdata;
		logic [31:0] word;
		logic [63:0] opa;
		logic [63:0] opb;
		logic [3:0]  op;
		logic [5:0]  lvl;
		rst_n_i = 1'b0;
		uop_valid_i = 1'b0;
		uop_i = '0;
		pc_i = '0;
		a_i = '0;
		b_i = '0;
		t_i = '0;
		imm_i = '0;
		irq_level_i = '0;
		psel_i = 1'b0;
		penable_i = 1'b0;
		pwrite_i = 1'b0;
		paddr_i = '0;
		pwdata_i = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n_i = 1'b1;

		// Outputs and all registers start at zero
		@(negedge clk);
		compare_outputs();
		apb_read(reg_ctrl, rdata);
		check_value("ctrl", 64'(rdata), 64'd0);
		apb_read(reg_taken, rdata);
		check_value("taken count", 64'(rdata), 64'd0);
		apb_read(reg_flow, rdata);
		check_value("flow count", 64'(rdata), 64'd0);

		// Conditional and loop branches, roughly one slot in eight left empty
		for (int i = 0; i < n_branch; i++)
		begin
			case (2'(rand_bits(2)))
				2'd1: op = op_ibcc;
				2'd2: op = op_dbcc;
				default: op = op_bcc;
			endcase
			word = {op, 1'b0, 3'(rand_bits(3)), 24'(rand_bits(24))};
			opa = pick_operand(rand_bits(64));
			opb = pick_operand(opa);
			issue_uop(3'(rand_bits(3)) != 3'd0, word, rand_bits(64), opa, opb,
				rand_bits(64), rand_bits(64), 6'(rand_bits(6)));
		end
		flush_pipe();
		check_counters();

		// Calls and returns, with a few nops mixed in
		for (int i = 0; i < n_link; i++)
		begin
			case (2'(rand_bits(2)))
				2'd0: op = op_bsr;
				2'd1: op = op_jsr;
				2'd2: op = op_ret;
				default: op = op_nop;
			endcase
			word = {op, 1'(rand_bits(1)), 27'(rand_bits(27))};
			issue_uop(1'b1, word, rand_bits(64), rand_bits(64), rand_bits(64),
				rand_bits(64), rand_bits(64), 6'(rand_bits(6)));
		end
		flush_pipe();
		check_counters();

		// Interrupt checks against fresh mie and ipl values each round
		for (int r = 0; r < n_irq_rounds; r++)
		begin
			word = 32'(rand_bits(32));
			apb_write(reg_ctrl, word);
			mie_m = word[8];
			ipl_m = word[5:0];
			apb_read(reg_ctrl, rdata);
			check_value("ctrl", 64'(rdata), 64'({mie_m, 2'b00, ipl_m}));
			for (int j = 0; j < n_irq; j++)
			begin
				lvl = (2'(rand_bits(2)) == 2'd0) ? nmi_level : 6'(rand_bits(6));
				issue_uop(1'b1, {op_irqchk, 28'(rand_bits(28))}, rand_bits(64),
					rand_bits(64), rand_bits(64), rand_bits(64), rand_bits(64), lvl);
			end
			flush_pipe();
			check_counters();
		end

		$display("Result: PASSED");
		$finish;
	end

endmodule

// ==== fcu.f ====
rtl/fcu_pkg.sv
rtl/fcu_event_counter.sv
rtl/fcu_apb_fsm.sv
rtl/fcu_csr.sv
rtl/fcu_branch_eval.sv
rtl/fcu_result_unit.sv
rtl/fcu_top.sv
sim/fcu_asserts.sv
sim/fcu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it, the exit status follows the simulation
cd "$(dirname "$0")" \
	&& verilator --binary --assert -j 0 --top-module fcu_tb -f fcu.f --Mdir obj_dir -o fcu_sim \
	&& ./obj_dir/fcu_sim \
	|| { echo "build or simulation failed" >&2; exit 1; }
